// File: logic/updi_pkg.sv
// updi definitions shared by the bring-up sequencer, frame transmitter and receiver
package updi_pkg;

	// instruction class, sits in opcode bits 7:5
	typedef enum logic [2:0] {
		OP_LDS,
		OP_LD,
		OP_STS,
		OP_ST,
		OP_LDCS,
		OP_REPEAT,
		OP_STCS,
		OP_KEY
	} updi_opcode_e;

	// ldcs / stcs: class plus control/status register address
	typedef struct packed {
		updi_opcode_e op;
		logic [4:0] addr;
	} updi_cs_view_t;

	// ld / st / repeat / key: class, pointer mode and size
	typedef struct packed {
		updi_opcode_e op;
		logic rsvd;
		logic [1:0] ptr;
		logic [1:0] size;
	} updi_ptr_view_t;

	typedef union packed {
		updi_cs_view_t cs;
		updi_ptr_view_t ptr;
	} updi_opcode_u;

	// one outgoing instruction
	typedef struct packed {
		updi_opcode_u op;
		logic [15:0] data;
		logic [1:0] data_len;
		logic key;
		logic ack;
		logic [1:0] rx_count;
	} updi_frame_t;

	typedef enum logic [2:0] {
		ERR_NONE,
		ERR_BAD_STATUS,
		ERR_NO_KEY,
		ERR_BAD_ACK,
		ERR_RX_TIMEOUT,
		ERR_PHY
	} updi_err_e;

	localparam logic [7:0] UPDI_SYNC = 8'h55;
	localparam logic [7:0] UPDI_ACK = 8'h40;

	// ptr field encodings
	localparam logic [1:0] PTR_INC = 2'd1;
	localparam logic [1:0] PTR_ADDR = 2'd2;
	localparam logic [1:0] SIZE_BYTE = 2'd0;
	localparam logic [1:0] SIZE_WORD = 2'd1;

	localparam logic [4:0] CS_STATUSA = 5'h00;
	localparam logic [4:0] CS_KEY_STATUS = 5'h07;
	localparam logic [4:0] CS_RESET_REQ = 5'h08;
	localparam logic [4:0] CS_SYS_STATUS = 5'h0B;

	localparam logic [7:0] RESET_SIGNATURE = 8'h59;
	localparam logic [15:0] SIGROW_BASE = 16'h1100;

	// byte 0 in bits 7:0, so the key goes out least significant byte first
	localparam logic [63:0] KEY_NVMPROG = 64'h4E56_4D50_726F_6720;

endpackage

// File: logic/updi_frame_tx.sv
// updi frame transmitter, writes one instruction frame to the uart tx fifo and checks its ack
`timescale 1ns/1ns

module updi_frame_tx (
	input logic clk,
	input logic rst,
	input logic frame_start,
	input updi_pkg::updi_frame_t frame,
	input logic tx_full,
	input logic [7:0] rx_data,
	input logic rx_empty,
	output logic [7:0] tx_data,
	output logic tx_wr,
	output logic ack_rd,
	output logic frame_sent,
	output logic frame_done,
	output logic ack_error
);
	import updi_pkg::*;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_SEND,
		TX_ACK
	} tx_state_e;

	tx_state_e state;
	updi_frame_t cur;
	logic [3:0] idx;
	logic [3:0] last_idx;
	logic [3:0] key_idx;

	// sync + opcode, then 8 key bytes or the inline data bytes
	assign last_idx = cur.key ? 4'd9 : 4'd1 + {2'b00, cur.data_len};
	assign key_idx = idx - 4'd2;

	always_comb begin
		if (idx == 4'd0) begin
			tx_data = UPDI_SYNC;
		end else if (idx == 4'd1) begin
			tx_data = cur.op;
		end else if (cur.key) begin
			tx_data = KEY_NVMPROG[{key_idx[2:0], 3'b000} +: 8];
		end else begin
			// inline data goes out lsb first
			tx_data = idx[0] ? cur.data[15:8] : cur.data[7:0];
		end
	end

	assign tx_wr = (state == TX_SEND) && !tx_full;
	assign ack_rd = (state == TX_ACK) && !rx_empty;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= TX_IDLE;
			idx <= '0;
			frame_sent <= 1'b0;
			frame_done <= 1'b0;
			ack_error <= 1'b0;
		end else begin
			frame_sent <= 1'b0;
			frame_done <= 1'b0;
			ack_error <= 1'b0;
			case (state)
				TX_IDLE: begin
					if (frame_start) begin
						state <= TX_SEND;
						idx <= '0;
					end
				end
				TX_SEND: begin
					if (tx_wr) begin
						if (idx == last_idx) begin
							frame_sent <= 1'b1;
							if (cur.ack) begin
								state <= TX_ACK;
							end else begin
								frame_done <= 1'b1;
								state <= TX_IDLE;
							end
						end else begin
							idx <= idx + 4'd1;
						end
					end
				end
				TX_ACK: begin
					if (ack_rd) begin
						state <= TX_IDLE;
						frame_done <= (rx_data == UPDI_ACK);
						ack_error <= (rx_data != UPDI_ACK);
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == TX_IDLE && frame_start) begin
			cur <= frame;
		end
	end

endmodule

// File: logic/updi_rx_collect.sv
// updi response receiver, pops a given number of bytes from the uart rx fifo with idle timeout
`timescale 1ns/1ns

module updi_rx_collect #(
	parameter int TIMEOUT_CLKS = 100
) (
	input logic clk,
	input logic rst,
	input logic frame_start,
	input logic [1:0] rx_count,
	input logic frame_sent,
	input logic [7:0] rx_data,
	input logic rx_empty,
	output logic rx_rd,
	output logic rx_valid,
	output logic [7:0] rx_byte,
	output logic rx_done,
	output logic rx_timeout
);

	localparam int CW = $clog2(TIMEOUT_CLKS + 1);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_ARMED,
		RX_COLLECT
	} rx_state_e;

	rx_state_e state;
	logic [1:0] remaining;
	logic [CW-1:0] idle_cnt;

	assign rx_rd = (state == RX_COLLECT) && !rx_empty;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= RX_IDLE;
			remaining <= '0;
			idle_cnt <= '0;
			rx_valid <= 1'b0;
			rx_done <= 1'b0;
			rx_timeout <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			rx_done <= 1'b0;
			rx_timeout <= 1'b0;
			case (state)
				RX_IDLE: begin
					// frames without a response leave the receiver idle
					if (frame_start && rx_count != 2'd0) begin
						remaining <= rx_count;
						state <= RX_ARMED;
					end
				end
				RX_ARMED: begin
					if (frame_sent) begin
						idle_cnt <= '0;
						state <= RX_COLLECT;
					end
				end
				RX_COLLECT: begin
					if (rx_rd) begin
						rx_valid <= 1'b1;
						idle_cnt <= '0;
						remaining <= remaining - 2'd1;
						if (remaining == 2'd1) begin
							rx_done <= 1'b1;
							state <= RX_IDLE;
						end
					end else if (idle_cnt == CW'(TIMEOUT_CLKS - 1)) begin
						rx_timeout <= 1'b1;
						state <= RX_IDLE;
					end else begin
						idle_cnt <= idle_cnt + 1'b1;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rx_rd) begin
			rx_byte <= rx_data;
		end
	end

endmodule

// File: logic/updi_sequencer.sv
// updi bring-up FSM, unlocks nvmprog, resets the device and reads its signature
`timescale 1ns/1ns

module updi_sequencer #(
	parameter int DELAY_CLKS = 100
) (
	input logic clk,
	input logic rst,
	input logic start,
	input logic phy_error,
	input logic double_break_done,
	input logic frame_done,
	input logic ack_error,
	input logic rx_valid,
	input logic [7:0] rx_byte,
	input logic rx_done,
	input logic rx_timeout,
	output logic busy,
	output logic double_break_start,
	output logic frame_start,
	output updi_pkg::updi_frame_t frame,
	output logic done,
	output logic error,
	output updi_pkg::updi_err_e err_code,
	output logic [23:0] device_id
);
	import updi_pkg::*;

	localparam int DW = $clog2(DELAY_CLKS + 1);

	typedef enum logic [3:0] {
		S_IDLE,
		S_DB_WAIT,
		S_STATUS,
		S_KEY,
		S_KEY_STATUS,
		S_RST_SET,
		S_RST_DELAY,
		S_RST_CLR,
		S_SYS_STATUS,
		S_POLL_DELAY,
		S_PTR,
		S_REPEAT,
		S_SIG
	} seq_state_e;

	seq_state_e state;
	seq_state_e state_next;
	logic [DW-1:0] delay_cnt;
	logic delay_done;
	logic launch;
	logic fail;
	updi_err_e fail_code;

	// frame issued on entry to each step
	function automatic updi_frame_t step_frame(seq_state_e s);
		updi_frame_t f;
		f = '0;
		case (s)
			S_STATUS: begin
				f.op.cs.op = OP_LDCS;
				f.op.cs.addr = CS_STATUSA;
				f.rx_count = 2'd1;
			end
			S_KEY: begin
				// size 0 on key means 8 bytes
				f.op.ptr.op = OP_KEY;
				f.key = 1'b1;
			end
			S_KEY_STATUS, S_SYS_STATUS: begin
				f.op.cs.op = OP_LDCS;
				f.op.cs.addr = (s == S_KEY_STATUS) ? CS_KEY_STATUS : CS_SYS_STATUS;
				f.rx_count = 2'd1;
			end
			S_RST_SET, S_RST_CLR: begin
				f.op.cs.op = OP_STCS;
				f.op.cs.addr = CS_RESET_REQ;
				f.data = (s == S_RST_SET) ? {8'h00, RESET_SIGNATURE} : 16'h0000;
				f.data_len = 2'd1;
			end
			S_PTR: begin
				f.op.ptr.op = OP_ST;
				f.op.ptr.ptr = PTR_ADDR;
				f.op.ptr.size = SIZE_WORD;
				f.data = SIGROW_BASE;
				f.data_len = 2'd2;
				f.ack = 1'b1;
			end
			S_REPEAT: begin
				// 2 repeats, 3 loads in total
				f.op.ptr.op = OP_REPEAT;
				f.data = 16'h0002;
				f.data_len = 2'd1;
			end
			S_SIG: begin
				f.op.ptr.op = OP_LD;
				f.op.ptr.ptr = PTR_INC;
				f.op.ptr.size = SIZE_BYTE;
				f.rx_count = 2'd3;
			end
			default: f = '0;
		endcase
		return f;
	endfunction

	assign busy = (state != S_IDLE);
	assign delay_done = (delay_cnt == DW'(DELAY_CLKS - 1));
	assign launch = (state_next != state) &&
		!(state_next inside {S_IDLE, S_DB_WAIT, S_RST_DELAY, S_POLL_DELAY});

	always_comb begin
		state_next = state;
		fail = 1'b0;
		fail_code = ERR_NONE;
		if (state != S_IDLE && phy_error) begin
			fail = 1'b1;
			fail_code = ERR_PHY;
		end else if (state != S_IDLE && rx_timeout) begin
			fail = 1'b1;
			fail_code = ERR_RX_TIMEOUT;
		end else if (state != S_IDLE && ack_error) begin
			fail = 1'b1;
			fail_code = ERR_BAD_ACK;
		end else begin
			case (state)
				S_IDLE: if (start) state_next = S_DB_WAIT;
				S_DB_WAIT: if (double_break_done) state_next = S_STATUS;
				S_STATUS: begin
					if (rx_done) begin
						state_next = S_KEY;
						fail = (rx_byte == 8'h00);
						fail_code = ERR_BAD_STATUS;
					end
				end
				S_KEY: if (frame_done) state_next = S_KEY_STATUS;
				S_KEY_STATUS: begin
					// bit 4 is the nvmprog key accepted flag
					if (rx_done) begin
						state_next = S_RST_SET;
						fail = !rx_byte[4];
						fail_code = ERR_NO_KEY;
					end
				end
				S_RST_SET: if (frame_done) state_next = S_RST_DELAY;
				S_RST_DELAY: if (delay_done) state_next = S_RST_CLR;
				S_RST_CLR: if (frame_done) state_next = S_SYS_STATUS;
				S_SYS_STATUS: begin
					// keep polling until the device reports nvmprog mode
					if (rx_done) state_next = rx_byte[3] ? S_PTR : S_POLL_DELAY;
				end
				S_POLL_DELAY: if (delay_done) state_next = S_SYS_STATUS;
				S_PTR: if (frame_done) state_next = S_REPEAT;
				S_REPEAT: if (frame_done) state_next = S_SIG;
				S_SIG: if (rx_done) state_next = S_IDLE;
				default: state_next = S_IDLE;
			endcase
		end
		if (fail) begin
			state_next = S_IDLE;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			delay_cnt <= '0;
			frame_start <= 1'b0;
			double_break_start <= 1'b0;
			done <= 1'b0;
			error <= 1'b0;
			err_code <= ERR_NONE;
		end else begin
			state <= state_next;
			frame_start <= launch;
			double_break_start <= (state == S_IDLE) && start;
			done <= (state == S_SIG) && rx_done && !fail;
			if (state == S_IDLE && start) begin
				error <= 1'b0;
				err_code <= ERR_NONE;
			end else if (fail) begin
				error <= 1'b1;
				err_code <= fail_code;
			end
			// one counter times both the reset gap and the poll gap
			if (state_next != state) begin
				delay_cnt <= '0;
			end else if (state == S_RST_DELAY || state == S_POLL_DELAY) begin
				delay_cnt <= delay_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (launch) begin
			frame <= step_frame(state_next);
		end
		if (state == S_IDLE && start) begin
			device_id <= '0;
		end else if (state == S_SIG && rx_valid) begin
			device_id <= {device_id[15:0], rx_byte};
		end
	end

endmodule

// File: logic/updi_programmer.sv
// updi programmer top level, bring-up sequencer driving the frame transmitter and receiver
`timescale 1ns/1ns

module updi_programmer #(
	parameter int DELAY_CLKS = 100,
	parameter int TIMEOUT_CLKS = 100
) (
	input logic clk,
	input logic rst,
	input logic start,
	input logic phy_error,
	input logic double_break_done,
	input logic tx_full,
	input logic [7:0] rx_data,
	input logic rx_empty,
	output logic busy,
	output logic double_break_start,
	output logic done,
	output logic error,
	output updi_pkg::updi_err_e err_code,
	output logic [23:0] device_id,
	output logic [7:0] tx_data,
	output logic tx_wr,
	output logic rx_rd
);
	import updi_pkg::*;

	updi_frame_t frame;
	logic frame_start;
	logic frame_sent;
	logic frame_done;
	logic ack_error;
	logic ack_rd;
	logic collect_rd;
	logic rx_valid;
	logic [7:0] rx_byte;
	logic rx_done;
	logic rx_timeout;

	// ack and response reads never overlap, half duplex
	assign rx_rd = ack_rd | collect_rd;

	updi_sequencer #(
		.DELAY_CLKS(DELAY_CLKS)
	) u_sequencer (
		.clk(clk),
		.rst(rst),
		.start(start),
		.phy_error(phy_error),
		.double_break_done(double_break_done),
		.frame_done(frame_done),
		.ack_error(ack_error),
		.rx_valid(rx_valid),
		.rx_byte(rx_byte),
		.rx_done(rx_done),
		.rx_timeout(rx_timeout),
		.busy(busy),
		.double_break_start(double_break_start),
		.frame_start(frame_start),
		.frame(frame),
		.done(done),
		.error(error),
		.err_code(err_code),
		.device_id(device_id)
	);

	updi_frame_tx u_frame_tx (
		.clk(clk),
		.rst(rst),
		.frame_start(frame_start),
		.frame(frame),
		.tx_full(tx_full),
		.rx_data(rx_data),
		.rx_empty(rx_empty),
		.tx_data(tx_data),
		.tx_wr(tx_wr),
		.ack_rd(ack_rd),
		.frame_sent(frame_sent),
		.frame_done(frame_done),
		.ack_error(ack_error)
	);

	updi_rx_collect #(
		.TIMEOUT_CLKS(TIMEOUT_CLKS)
	) u_rx_collect (
		.clk(clk),
		.rst(rst),
		.frame_start(frame_start),
		.rx_count(frame.rx_count),
		.frame_sent(frame_sent),
		.rx_data(rx_data),
		.rx_empty(rx_empty),
		.rx_rd(collect_rd),
		.rx_valid(rx_valid),
		.rx_byte(rx_byte),
		.rx_done(rx_done),
		.rx_timeout(rx_timeout)
	);

endmodule

// File: dv/tb_updi_programmer.sv
// testbench for the updi bring-up programmer, replays byte traces through uart fifo models
`timescale 1ns/1ns

module tb_updi_programmer;
	import updi_pkg::*;

	localparam int DELAY_CLKS = 20;
	localparam int TIMEOUT_CLKS = 50;
	localparam int RUN_LIMIT = 5000;
	localparam int RUN_COUNT = 7;

	logic clk;
	logic rst;
	logic start;
	logic phy_error;
	logic double_break_done;
	logic tx_full;
	logic [7:0] rx_data;
	logic rx_empty;
	logic busy;
	logic double_break_start;
	logic done;
	logic error;
	updi_err_e err_code;
	logic [23:0] device_id;
	logic [7:0] tx_data;
	logic tx_wr;
	logic rx_rd;

	// expected tx stream, rx bytes and the tx count that releases each rx byte
	logic [7:0] exp_tx[$];
	logic [7:0] rx_bytes[$];
	int rx_gate[$];
	logic [2:0] exp_code;
	logic [23:0] exp_id;
	int tx_total;
	int db_cnt;
	int fd;
	logic [16:0] lfsr;

	updi_programmer #(
		.DELAY_CLKS(DELAY_CLKS),
		.TIMEOUT_CLKS(TIMEOUT_CLKS)
	) dut (
		.clk(clk),
		.rst(rst),
		.start(start),
		.phy_error(phy_error),
		.double_break_done(double_break_done),
		.tx_full(tx_full),
		.rx_data(rx_data),
		.rx_empty(rx_empty),
		.busy(busy),
		.double_break_start(double_break_start),
		.done(done),
		.error(error),
		.err_code(err_code),
		.device_id(device_id),
		.tx_data(tx_data),
		.tx_wr(tx_wr),
		.rx_rd(rx_rd)
	);

	// fibonacci lfsr, x^17 + x^14 + 1
	function automatic logic [16:0] lfsr_next(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	function automatic logic random_bit();
		lfsr = lfsr_next(lfsr);
		return lfsr[0];
	endfunction

	function automatic logic [3:0] hex_value(input logic [7:0] ch);
		if (ch >= "a") begin
			return 4'(ch - "a" + 8'd10);
		end else if (ch >= "A") begin
			return 4'(ch - "A" + 8'd10);
		end
		return 4'(ch - "0");
	endfunction

	task automatic stop_run();
		$display("TEST FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_problem(input string msg);
		$display("%s", msg);
		stop_run();
	endtask

	task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			$display("FAIL %s got 0x%0h expected 0x%0h", name, got, want);
			stop_run();
		end
	endtask

	// fifo and double break inputs for the coming clock edge
	task automatic drive_inputs();
		logic bit_a;
		logic bit_b;
		logic stall_rx;
		logic rx_ready;
		// each fifo stalls on about a quarter of the cycles
		bit_a = random_bit();
		bit_b = random_bit();
		tx_full <= bit_a & bit_b;
		bit_a = random_bit();
		bit_b = random_bit();
		stall_rx = bit_a & bit_b;
		rx_ready = 1'b0;
		if (rx_bytes.size() != 0) begin
			rx_ready = (tx_total >= rx_gate[0]);
		end
		rx_empty <= !(rx_ready && !stall_rx);
		if (rx_ready) begin
			rx_data <= rx_bytes[0];
		end
		// double break finishes a few cycles after it was requested
		double_break_done <= (db_cnt == 1);
		if (db_cnt != 0) begin
			db_cnt = db_cnt - 1;
		end
	endtask

	// fifo accesses the DUT makes at the coming clock edge
	task automatic sample_outputs();
		logic [7:0] want;
		if (tx_wr && tx_full) begin
			report_problem("DUT wrote the TX FIFO while it was full");
		end
		if (tx_wr) begin
			if (exp_tx.size() == 0) begin
				report_problem($sformatf("DUT wrote byte 0x%02h past the end of the trace", tx_data));
			end
			want = exp_tx.pop_front();
			check_equal("tx_data", 32'(tx_data), 32'(want));
			tx_total = tx_total + 1;
		end
		if (rx_rd && rx_empty) begin
			report_problem("DUT read the RX FIFO while it was empty");
		end
		if (rx_rd) begin
			if (rx_bytes.size() == 0) begin
				report_problem("DUT read the RX FIFO while it held no byte");
			end
			rx_bytes.delete(0);
			rx_gate.delete(0);
		end
		if (double_break_start) begin
			db_cnt = 4;
		end
	endtask

	// drive on the rising edge, look at the DUT on the falling edge
	task automatic step_clock();
		@(posedge clk);
		drive_inputs();
		@(negedge clk);
		sample_outputs();
	endtask

	// reads trace lines up to and including the next E group
	task automatic load_run(output bit found);
		string line;
		int rc;
		int len;
		int evals;
		int ntx;
		int ndig;
		logic [31:0] val;
		logic [7:0] c;
		logic [7:0] first;
		logic [7:0] mode;
		exp_tx.delete();
		rx_bytes.delete();
		rx_gate.delete();
		evals = 0;
		ntx = 0;
		mode = 8'h00;
		first = 8'h00;
		while (evals < 2 && !$feof(fd)) begin
			rc = $fgets(line, fd);
			len = line.len();
			ndig = 0;
			val = '0;
			if (rc != 0 && line.getc(0) != "#") begin
				for (int i = 0; i <= len; i++) begin
					c = (i < len) ? line.getc(i) : 8'h20;
					if (c == 8'h20 || c == 8'h09 || c == 8'h0a || c == 8'h0d) begin
						// a single character is a tag, longer tokens are values
						if (ndig == 1) begin
							mode = first;
						end else if (ndig > 1 && mode == "T") begin
							exp_tx.push_back(val[7:0]);
							ntx = ntx + 1;
						end else if (ndig > 1 && mode == "R") begin
							rx_bytes.push_back(val[7:0]);
							rx_gate.push_back(tx_total + ntx);
						end else if (ndig > 1 && mode == "E") begin
							if (evals == 0) begin
								exp_code = val[2:0];
							end else begin
								exp_id = val[23:0];
							end
							evals = evals + 1;
						end else if (ndig > 1) begin
							report_problem("trace holds a value before any T, R or E tag");
						end
						ndig = 0;
						val = '0;
					end else begin
						if (ndig == 0) begin
							first = c;
						end
						val = {val[27:0], hex_value(c)};
						ndig = ndig + 1;
					end
				end
			end
		end
		found = (evals == 2);
	endtask

	task automatic run_one();
		int cycles;
		@(posedge clk);
		drive_inputs();
		start <= 1'b1;
		@(negedge clk);
		sample_outputs();
		@(posedge clk);
		drive_inputs();
		start <= 1'b0;
		@(negedge clk);
		sample_outputs();
		check_equal("double_break_start", 32'(double_break_start), 32'd1);
		check_equal("busy", 32'(busy), 32'd1);
		cycles = 0;
		while (!done && !error) begin
			step_clock();
			cycles = cycles + 1;
			if (cycles > RUN_LIMIT) begin
				report_problem("timed out waiting for done or error");
			end
		end
		check_equal("done", 32'(done), 32'(exp_code == 3'd0));
		check_equal("err_code", 32'(err_code), 32'(exp_code));
		check_equal("busy", 32'(busy), 32'd0);
		check_equal("device_id", 32'(device_id), 32'(exp_id));
		check_equal("tx bytes left", 32'(exp_tx.size()), 32'd0);
		check_equal("rx bytes left", 32'(rx_bytes.size()), 32'd0);
		// done lasts one cycle, error stays up
		step_clock();
		check_equal("done", 32'(done), 32'd0);
		check_equal("error", 32'(error), 32'(exp_code != 3'd0));
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		bit found;
		int runs;
		rst = 1'b1;
		start = 1'b0;
		phy_error = 1'b0;
		double_break_done = 1'b0;
		tx_full = 1'b0;
		rx_data = 8'h00;
		rx_empty = 1'b1;
		lfsr = 17'd71808;
		tx_total = 0;
		db_cnt = 0;
		runs = 0;
		fd = $fopen("dv/updi_trace.txt", "r");
		if (fd == 0) begin
			report_problem("cannot open dv/updi_trace.txt");
		end
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		load_run(found);
		while (found) begin
			run_one();
			runs = runs + 1;
			load_run(found);
		end
		$fclose(fd);
		check_equal("run count", 32'(runs), 32'(RUN_COUNT));
		$display("TEST PASS");
		$finish;
	end

endmodule

// File: all.f
logic/updi_pkg.sv
logic/updi_frame_tx.sv
logic/updi_rx_collect.sv
logic/updi_sequencer.sv
logic/updi_programmer.sv
dv/tb_updi_programmer.sv

// File: run.sh
#!/usr/bin/env bash
# builds the updi programmer testbench with verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 -f all.f --top-module tb_updi_programmer -o sim_updi

# a failed check ends in $fatal, which gives a nonzero exit status
./obj_dir/sim_updi

// File: dv/updi_trace.txt
# each line holds one-letter tags, each followed by hex values of two or more digits
# T marks expected tx bytes and R marks rx bytes that appear once the tx bytes before them are written
# E gives the expected err_code and device_id and closes the run
# clean bring-up
T 55 80 R 30 T 55 E0 20 67 6F 72 50 4D 56 4E 55 87 R 10
T 55 C8 59 55 C8 00 55 8B R 08 T 55 69 00 11 R 40 T 55 A0 02 55 24
R 1E 95 0F E 00 1E950F
# nvmprog flag clear on the first two polls
T 55 80 R 30 T 55 E0 20 67 6F 72 50 4D 56 4E 55 87 R 10
T 55 C8 59 55 C8 00 55 8B R 00 T 55 8B R 00 T 55 8B R 08
T 55 69 00 11 R 40 T 55 A0 02 55 24 R 1E 95 0F E 00 1E950F
# statusa reads zero
T 55 80 R 00 E 01 000000
# key status with bit 4 clear
T 55 80 R 30 T 55 E0 20 67 6F 72 50 4D 56 4E 55 87 R EF E 02 000000
# pointer write answered with 00
T 55 80 R 30 T 55 E0 20 67 6F 72 50 4D 56 4E 55 87 R 10
T 55 C8 59 55 C8 00 55 8B R 08 T 55 69 00 11 R 00 E 03 000000
# device sends only two signature bytes
T 55 80 R 30 T 55 E0 20 67 6F 72 50 4D 56 4E 55 87 R 10
T 55 C8 59 55 C8 00 55 8B R 08 T 55 69 00 11 R 40 T 55 A0 02 55 24
R 1E 95 E 04 001E95
# clean bring-up again after the error runs
T 55 80 R 30 T 55 E0 20 67 6F 72 50 4D 56 4E 55 87 R 10
T 55 C8 59 55 C8 00 55 8B R 08 T 55 69 00 11 R 40 T 55 A0 02 55 24
R 1E 93 0B E 00 1E930B
